//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -j 0 --top-module tb_caches -f vlog.f -o tb_caches
	./obj_dir/tb_caches | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- caches_top.sv
// data cache subsystem top joining the cache, the ram model and the snoop controller
module caches_top (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  logic                 halt,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  output logic                 dhit,
  output logic                 flushed,
  output cpu_types_pkg::word_t dmemload,
  input  logic                 snoop_req,
  input  cpu_types_pkg::word_t snoop_addr,
  input  logic                 snoop_inv,
  output logic                 snoop_done,
  output logic                 snoop_hit,
  output logic                 mem_wen,
  output cpu_types_pkg::word_t mem_addr,
  output cpu_types_pkg::word_t mem_wdata
);

  logic dREN, dWEN, dwait;
  logic ccwait, ccinv, ccwrite;
  cpu_types_pkg::word_t daddr, dstore, dload, ccsnoopaddr;

  dcache i_dcache (
    .CLK(CLK), .nRST(nRST),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload),
    .ccwait(ccwait), .ccinv(ccinv), .ccsnoopaddr(ccsnoopaddr),
    .cctrans(), .ccwrite(ccwrite)   // cctrans has no listener without the full protocol
  );

  ram i_ram (
    .CLK(CLK), .nRST(nRST),
    .dREN(dREN), .dWEN(dWEN), .daddr(daddr), .dstore(dstore),
    .dwait(dwait), .dload(dload)
  );

  coherence_control i_coherence_control (
    .CLK(CLK), .nRST(nRST),
    .snoop_req(snoop_req), .snoop_inv(snoop_inv), .snoop_addr(snoop_addr),
    .dREN(dREN), .dWEN(dWEN), .ccwrite(ccwrite),
    .ccwait(ccwait), .ccinv(ccinv), .ccsnoopaddr(ccsnoopaddr),
    .snoop_done(snoop_done), .snoop_hit(snoop_hit)
  );

  // one mem_wen pulse per word actually stored
  assign mem_wen   = dWEN && !dwait;
  assign mem_addr  = daddr;
  assign mem_wdata = dstore;

endmodule

//--- coherence_control.sv
// snoop sequencer that holds external snoops off during bus words and reports presence
module coherence_control (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 snoop_req,
  input  logic                 snoop_inv,
  input  cpu_types_pkg::word_t snoop_addr,
  input  logic                 dREN,
  input  logic                 dWEN,
  input  logic                 ccwrite,
  output logic                 ccwait,
  output logic                 ccinv,
  output cpu_types_pkg::word_t ccsnoopaddr,
  output logic                 snoop_done,
  output logic                 snoop_hit
);

  typedef enum logic [1:0] {IDLE, WAIT, ASSERT, REPORT} state_t;

  state_t state;

  cpu_types_pkg::dcachef_t snoop_f;
  cpu_types_pkg::word_t    addr_q;
  logic inv_q;
  logic armed;   // first quiet cycle of the assert window seen
  logic bus_quiet;

  // snoops work on whole blocks
  always_comb begin
    snoop_f        = snoop_addr;
    snoop_f.blkoff = 1'b0;
    snoop_f.bytoff = '0;
  end

  assign bus_quiet   = !dREN && !dWEN;
  assign ccwait      = (state == ASSERT);
  assign ccinv       = ccwait && inv_q;
  assign ccsnoopaddr = addr_q;
  assign snoop_done  = (state == REPORT);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state     <= IDLE;
      inv_q     <= 1'b0;
      armed     <= 1'b0;
      snoop_hit <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (snoop_req) begin
            inv_q <= snoop_inv;
            state <= WAIT;
          end
        end
        WAIT: begin
          if (bus_quiet) begin
            armed <= 1'b0;
            state <= ASSERT;
          end
        end
        ASSERT: begin
          // a miss that started under us restarts the two-cycle window
          if (!bus_quiet) begin
            armed <= 1'b0;
          end else if (!armed) begin
            armed <= 1'b1;
          end else begin
            snoop_hit <= ccwrite;   // answer registered by the cache
            state     <= REPORT;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if ((state == IDLE) && snoop_req) begin
      addr_q <= snoop_f;
    end
  end

endmodule

//--- cpu_types_pkg.sv
// shared types and constants for the data cache subsystem
package cpu_types_pkg;

  // data word
  typedef logic [31:0] word_t;

  // address field widths
  localparam int TAG_W = 26;
  localparam int IDX_W = 3;

  // cache geometry
  localparam int SETS = 8;
  localparam int WAYS = 2;   // one lru bit per set covers two ways

  // ram model
  localparam int RAM_LATENCY = 2;           // wait cycles before each word completes
  localparam int RAM_WORDS   = 1024;
  localparam logic [31:0] RAM_PATTERN = 32'h5a3c_96e1;   // word starts as byte address ^ pattern

  // address split as seen by the data cache
  typedef struct packed {
    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] idx;
    logic             blkoff;   // word within the two-word block
    logic [1:0]       bytoff;
  } dcachef_t;

endpackage

//--- dcache.sv
// two-way set-associative write-back data cache with lru replacement, flush and snoop handling
module dcache (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dmemREN,
  input  logic                 dmemWEN,
  input  logic                 halt,
  input  cpu_types_pkg::word_t dmemaddr,
  input  cpu_types_pkg::word_t dmemstore,
  output logic                 dhit,
  output logic                 flushed,
  output cpu_types_pkg::word_t dmemload,
  output logic                 dREN,
  output logic                 dWEN,
  output cpu_types_pkg::word_t daddr,
  output cpu_types_pkg::word_t dstore,
  input  logic                 dwait,
  input  cpu_types_pkg::word_t dload,
  input  logic                 ccwait,
  input  logic                 ccinv,
  input  cpu_types_pkg::word_t ccsnoopaddr,
  output logic                 cctrans,
  output logic                 ccwrite
);

  typedef struct packed {
    logic [cpu_types_pkg::TAG_W-1:0] tag;
    cpu_types_pkg::word_t [1:0]      data;
  } entry_t;

  typedef enum logic [2:0] {
    IDLE,
    WB0,     // write back word 0 of a block
    WB1,
    FILL0,   // fetch word 0 of the missing block
    FILL1,
    FLUSH,   // scan for the next dirty block
    SNOOP,
    DONE
  } state_t;

  state_t state, state_nxt;

  // tag and data payload per way and set
  entry_t lines [cpu_types_pkg::WAYS][cpu_types_pkg::SETS];
  logic   valid [cpu_types_pkg::WAYS][cpu_types_pkg::SETS];
  logic   dirty [cpu_types_pkg::WAYS][cpu_types_pkg::SETS];
  logic [cpu_types_pkg::SETS-1:0] lru;   // way to evict next

  cpu_types_pkg::dcachef_t query;
  cpu_types_pkg::dcachef_t snp;
  cpu_types_pkg::dcachef_t bus;

  logic [cpu_types_pkg::IDX_W:0] fl_cnt;   // flush walk, msb is the way
  logic flushing;
  logic fl_last;

  logic [cpu_types_pkg::WAYS-1:0] hit_vec;
  logic [cpu_types_pkg::WAYS-1:0] snp_vec;
  logic req, hit, hit_way, wr_hit;
  logic victim, victim_dirty;
  logic word_done;

  logic                          wb_way;
  logic [cpu_types_pkg::IDX_W-1:0] wb_set;
  entry_t                        wb_line;

  assign query = dmemaddr;
  assign snp   = ccsnoopaddr;

  // tag compare on both ways for the datapath and for the snooped set
  always_comb begin
    for (int w = 0; w < cpu_types_pkg::WAYS; w++) begin
      hit_vec[w] = valid[w][query.idx] && (lines[w][query.idx].tag == query.tag);
      snp_vec[w] = valid[w][snp.idx] && (lines[w][snp.idx].tag == snp.tag);
    end
  end

  assign req          = dmemREN || dmemWEN;
  assign hit          = |hit_vec;
  assign hit_way      = hit_vec[1];
  assign victim       = lru[query.idx];
  assign victim_dirty = dirty[victim][query.idx];
  assign word_done    = !dwait;
  assign fl_last      = &fl_cnt;

  // write-back source is the lru victim on a miss or the walk position on a flush
  assign wb_way  = flushing ? fl_cnt[cpu_types_pkg::IDX_W] : victim;
  assign wb_set  = flushing ? fl_cnt[cpu_types_pkg::IDX_W-1:0] : query.idx;
  assign wb_line = lines[wb_way][wb_set];

  // hits are served only from idle and only when no snoop is waiting
  assign dhit     = (state == IDLE) && !ccwait && req && hit;
  assign wr_hit   = dhit && dmemWEN && !dmemREN;   // read wins if both strobes are up
  assign dmemload = lines[hit_way][query.idx].data[query.blkoff];
  assign flushed  = (state == DONE);

  assign dREN   = (state == FILL0) || (state == FILL1);
  assign dWEN   = (state == WB0) || (state == WB1);
  assign dstore = wb_line.data[state == WB1];

  always_comb begin
    bus = '0;
    if (dWEN) begin
      bus.tag = wb_line.tag;   // rebuild the victim's address
      bus.idx = wb_set;
    end else begin
      bus.tag = query.tag;
      bus.idx = query.idx;
    end
    bus.blkoff = (state == WB1) || (state == FILL1);
  end

  assign daddr = bus;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ccwait) begin
          state_nxt = SNOOP;
        end else if (req) begin
          if (!hit) begin
            state_nxt = victim_dirty ? WB0 : FILL0;
          end
        end else if (halt) begin
          state_nxt = FLUSH;
        end
      end
      WB0: begin
        if (word_done) begin
          state_nxt = WB1;
        end
      end
      WB1: begin
        if (word_done) begin
          if (!flushing) begin
            state_nxt = FILL0;
          end else begin
            state_nxt = fl_last ? DONE : FLUSH;
          end
        end
      end
      FILL0: begin
        if (word_done) begin
          state_nxt = FILL1;
        end
      end
      FILL1: begin
        if (word_done) begin
          state_nxt = IDLE;   // request is retried as a hit
        end
      end
      FLUSH: begin
        if (dirty[wb_way][wb_set]) begin
          state_nxt = WB0;
        end else if (fl_last) begin
          state_nxt = DONE;
        end
      end
      SNOOP: begin
        if (!ccwait) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = state;   // DONE holds until reset
    endcase
  end

  // control state, coherence strobes and lru
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state    <= IDLE;
      lru      <= '0;
      valid    <= '{default: '0};
      dirty    <= '{default: '0};
      fl_cnt   <= '0;
      flushing <= 1'b0;
      cctrans  <= 1'b0;
      ccwrite  <= 1'b0;
    end else begin
      state <= state_nxt;
      case (state)
        IDLE: begin
          if (ccwait) begin
            cctrans <= 1'b1;
            ccwrite <= |snp_vec;   // presence answer for the controller
          end else if (dhit) begin
            lru[query.idx] <= ~hit_way;
            cctrans        <= wr_hit && !dirty[hit_way][query.idx];   // clean block turns modified
            ccwrite        <= wr_hit && !dirty[hit_way][query.idx];
            if (wr_hit) begin
              dirty[hit_way][query.idx] <= 1'b1;
            end
          end else if (req) begin
            cctrans <= !victim_dirty;
            ccwrite <= victim_dirty;
          end else begin
            cctrans <= 1'b0;
            ccwrite <= 1'b0;
            if (halt) begin
              flushing <= 1'b1;
              fl_cnt   <= '0;
            end
          end
        end
        WB1: begin
          if (word_done) begin
            dirty[wb_way][wb_set] <= 1'b0;
            if (flushing) begin
              fl_cnt <= fl_cnt + 1'b1;
            end else begin
              cctrans <= 1'b1;   // fill follows
              ccwrite <= 1'b0;
            end
          end
        end
        FILL1: begin
          if (word_done) begin
            valid[victim][query.idx] <= 1'b1;
            dirty[victim][query.idx] <= 1'b0;
            cctrans                  <= 1'b0;
            ccwrite                  <= 1'b0;
          end
        end
        FLUSH: begin
          if (!dirty[wb_way][wb_set]) begin
            fl_cnt <= fl_cnt + 1'b1;
          end
        end
        SNOOP: begin
          if (ccwait) begin
            cctrans <= 1'b1;
            ccwrite <= |snp_vec;
            if (ccinv) begin
              // drop the matching way of the snooped set
              for (int w = 0; w < cpu_types_pkg::WAYS; w++) begin
                if (snp_vec[w]) begin
                  valid[w][snp.idx] <= 1'b0;
                  dirty[w][snp.idx] <= 1'b0;
                end
              end
            end
          end else begin
            cctrans <= 1'b0;
            ccwrite <= 1'b0;
          end
        end
        default: ;
      endcase
    end
  end

  // tag and data arrays
  always_ff @(posedge CLK) begin
    if (wr_hit) begin
      lines[hit_way][query.idx].data[query.blkoff] <= dmemstore;
    end
    if ((state == FILL0) && word_done) begin
      lines[victim][query.idx].data[0] <= dload;
    end
    if ((state == FILL1) && word_done) begin
      lines[victim][query.idx].data[1] <= dload;
      lines[victim][query.idx].tag     <= query.tag;
    end
  end

endmodule

//--- ram.sv
// word-addressed memory model with a fixed wait per word and pattern-filled start contents
module ram (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 dREN,
  input  logic                 dWEN,
  input  cpu_types_pkg::word_t daddr,
  input  cpu_types_pkg::word_t dstore,
  output logic                 dwait,
  output cpu_types_pkg::word_t dload
);

  typedef logic [$clog2(cpu_types_pkg::RAM_LATENCY+1)-1:0] lat_t;

  cpu_types_pkg::word_t mem [cpu_types_pkg::RAM_WORDS];

  logic [$clog2(cpu_types_pkg::RAM_WORDS)-1:0] word_idx;
  lat_t lat_cnt;
  logic strobe, word_done;

  // each word holds its byte address xor the pattern
  initial begin
    for (int i = 0; i < cpu_types_pkg::RAM_WORDS; i++) begin
      mem[i] = cpu_types_pkg::word_t'(i * 4) ^ cpu_types_pkg::RAM_PATTERN;
    end
  end

  assign word_idx  = daddr[2 +: $bits(word_idx)];   // drop the byte offset
  assign strobe    = dREN || dWEN;
  assign word_done = strobe && (lat_cnt == lat_t'(cpu_types_pkg::RAM_LATENCY));
  assign dwait     = strobe && !word_done;
  assign dload     = mem[word_idx];

  // wait counter restarts after each completed word
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lat_cnt <= '0;
    end else if (!strobe || word_done) begin
      lat_cnt <= '0;
    end else begin
      lat_cnt <= lat_cnt + 1'b1;
    end
  end

  always @(posedge CLK) begin
    if (word_done && dWEN) begin
      mem[word_idx] <= dstore;   // store lands in the completing cycle
    end
  end

endmodule

//--- tb_caches.sv
// directed testbench for the data cache subsystem
module tb_caches;

  logic CLK;
  logic nRST;
  logic dmemREN, dmemWEN, halt;
  logic dhit, flushed;
  logic snoop_req, snoop_inv, snoop_done, snoop_hit;
  logic mem_wen;
  cpu_types_pkg::word_t dmemaddr, dmemstore, dmemload;
  cpu_types_pkg::word_t snoop_addr, mem_addr, mem_wdata;

  cpu_types_pkg::word_t model [cpu_types_pkg::RAM_WORDS];   // memory as the datapath sees it
  cpu_types_pkg::word_t wb_addr_q [$];
  cpu_types_pkg::word_t wb_data_q [$];
  logic [31:0] lfsr;
  int errors;
  int checks;

  caches_top i_dut (
    .CLK(CLK), .nRST(nRST),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN), .halt(halt),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore),
    .dhit(dhit), .flushed(flushed), .dmemload(dmemload),
    .snoop_req(snoop_req), .snoop_addr(snoop_addr), .snoop_inv(snoop_inv),
    .snoop_done(snoop_done), .snoop_hit(snoop_hit),
    .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // record every word the cache stores to memory
  always @(negedge CLK) begin
    if (mem_wen) begin
      wb_addr_q.push_back(mem_addr);
      wb_data_q.push_back(mem_wdata);
    end
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic cpu_types_pkg::word_t random_word();
    cpu_types_pkg::word_t w;
    for (int i = 0; i < 32; i++) begin
      w[i] = lfsr_bit();
    end
    return w;
  endfunction

  // byte address of word 0 of a block from its tag and set index
  function automatic cpu_types_pkg::word_t block_base(input logic [25:0] tag,
                                                      input logic [2:0] set);
    return {tag, set, 3'b000};
  endfunction

  task automatic check_equal(input string what, input cpu_types_pkg::word_t got,
                             input cpu_types_pkg::word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // hold a request until dhit and hand back the load word and the cycles waited
  task automatic mem_access(input logic wr, input cpu_types_pkg::word_t addr,
                            input cpu_types_pkg::word_t wdata,
                            output cpu_types_pkg::word_t rdata, output int waited);
    waited    = 0;
    dmemREN   = !wr;
    dmemWEN   = wr;
    dmemaddr  = addr;
    dmemstore = wdata;
    @(negedge CLK);
    while (!dhit && waited < 64) begin   // a dirty miss needs well under 64 cycles
      waited++;
      @(negedge CLK);
    end
    if (!dhit) begin
      errors++;
      $display("no dhit came for the access to address %h", addr);
    end
    rdata = dmemload;
    @(posedge CLK);
    #10;
    dmemREN = 1'b0;
    dmemWEN = 1'b0;
  endtask

  task automatic read_check(input cpu_types_pkg::word_t addr, input string what,
                            output int waited);
    cpu_types_pkg::word_t data;
    mem_access(1'b0, addr, '0, data, waited);
    check_equal(what, data, model[addr[11:2]]);
  endtask

  task automatic write_word(input cpu_types_pkg::word_t addr,
                            input cpu_types_pkg::word_t data);
    cpu_types_pkg::word_t ignored;
    int waited;
    mem_access(1'b1, addr, data, ignored, waited);
    model[addr[11:2]] = data;
  endtask

  // one external snoop held until snoop_done
  task automatic snoop_probe(input cpu_types_pkg::word_t addr, input logic inv,
                             output logic hit);
    int n;
    n          = 0;
    snoop_req  = 1'b1;
    snoop_addr = addr;
    snoop_inv  = inv;
    @(negedge CLK);
    while (!snoop_done && n < 64) begin
      n++;
      @(negedge CLK);
    end
    if (!snoop_done) begin
      errors++;
      $display("snoop_done never came for the snoop of address %h", addr);
    end
    check_equal("snoop answer not before three cycles", 32'(n >= 3), 32'd1);
    hit = snoop_hit;
    @(posedge CLK);
    #10;
    snoop_req = 1'b0;
    snoop_inv = 1'b0;
  endtask

  // the two words of block blk are expected at slot pos of the write-back queue
  task automatic expect_writeback(input cpu_types_pkg::word_t blk, input int pos);
    cpu_types_pkg::word_t a;
    for (int w = 0; w < 2; w++) begin
      a = blk + 32'(w * 4);
      if (wb_addr_q.size() <= 2 * pos + w) begin
        errors++;
        $display("the write-back of address %h is missing", a);
      end else begin
        check_equal("write-back address", wb_addr_q[2 * pos + w], a);
        check_equal("write-back data", wb_data_q[2 * pos + w], model[a[11:2]]);
      end
    end
  endtask

  task automatic read_miss_then_hit();
    int waited;
    read_check(block_base(26'd1, 3'd0), "first read of an untouched word", waited);
    check_equal("first read is a miss", 32'(waited != 0), 32'd1);
    read_check(block_base(26'd1, 3'd0), "second read", waited);
    check_equal("second read hits with zero wait", 32'(waited), 32'd0);
  endtask

  task automatic write_read_back();
    cpu_types_pkg::word_t base;
    int waited;
    wb_addr_q.delete();
    wb_data_q.delete();
    for (int s = 1; s <= 3; s++) begin
      base = block_base(26'd2, 3'(s));
      write_word(base, random_word());
      read_check(base + 32'd4, "neighbour word before its write", waited);
      write_word(base + 32'd4, random_word());
      read_check(base, "word 0 read back", waited);
      read_check(base + 32'd4, "word 1 read back", waited);
    end
    check_equal("no write-back into free ways", 32'(wb_addr_q.size()), 32'd0);
  endtask

  task automatic dirty_eviction();
    cpu_types_pkg::word_t victim;
    int waited;
    victim = block_base(26'd3, 3'd4);
    wb_addr_q.delete();
    wb_data_q.delete();
    write_word(victim, random_word());
    write_word(victim + 32'd4, random_word());
    read_check(block_base(26'd4, 3'd4), "second tag in set 4", waited);
    check_equal("no write-back while a way is free", 32'(wb_addr_q.size()), 32'd0);
    read_check(block_base(26'd5, 3'd4), "third tag in set 4", waited);   // evicts the dirty way
    check_equal("write-back word count", 32'(wb_addr_q.size()), 32'd2);
    expect_writeback(victim, 0);
    read_check(victim, "evicted word 0 reread", waited);
    read_check(victim + 32'd4, "evicted word 1 reread", waited);
  endtask

  task automatic snoop_presence();
    logic hit;
    int waited;
    snoop_probe(block_base(26'd1, 3'd0), 1'b0, hit);
    check_equal("snoop of a cached clean block", 32'(hit), 32'd1);
    snoop_probe(block_base(26'd7, 3'd5), 1'b0, hit);
    check_equal("snoop of an uncached block", 32'(hit), 32'd0);
    snoop_probe(block_base(26'd1, 3'd0), 1'b1, hit);
    check_equal("snoop with invalidate", 32'(hit), 32'd1);
    read_check(block_base(26'd1, 3'd0), "read after invalidate", waited);
    check_equal("read after invalidate misses", 32'(waited != 0), 32'd1);
  endtask

  task automatic flush_dirty_blocks();
    cpu_types_pkg::word_t order [4];
    int n;
    write_word(block_base(26'd6, 3'd1), random_word());   // dirties way 1 of set 1
    order[0] = block_base(26'd2, 3'd1);
    order[1] = block_base(26'd2, 3'd2);
    order[2] = block_base(26'd2, 3'd3);
    order[3] = block_base(26'd6, 3'd1);
    wb_addr_q.delete();
    wb_data_q.delete();
    halt = 1'b1;
    n    = 0;
    @(negedge CLK);
    while (!flushed && n < 256) begin
      n++;
      @(negedge CLK);
    end
    if (!flushed) begin
      errors++;
      $display("flushed did not rise after halt");
    end
    check_equal("flush write-back word count", 32'(wb_addr_q.size()), 32'd8);
    for (int b = 0; b < 4; b++) begin
      expect_writeback(order[b], b);
    end
    repeat (4) begin
      @(negedge CLK);
      check_equal("flushed stays high", 32'(flushed), 32'd1);
    end
  endtask

  initial begin
    nRST       = 1'b0;
    dmemREN    = 1'b0;
    dmemWEN    = 1'b0;
    halt       = 1'b0;
    dmemaddr   = '0;
    dmemstore  = '0;
    snoop_req  = 1'b0;
    snoop_inv  = 1'b0;
    snoop_addr = '0;
    lfsr       = 32'h0bdae6cb;
    errors     = 0;
    checks     = 0;
    for (int i = 0; i < cpu_types_pkg::RAM_WORDS; i++) begin
      model[i] = 32'(i * 4) ^ cpu_types_pkg::RAM_PATTERN;
    end
    repeat (4) @(posedge CLK);
    #10;
    nRST = 1'b1;
    read_miss_then_hit();
    write_read_back();
    dirty_eviction();
    snoop_presence();
    flush_dirty_blocks();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog sized from about 30 worst-case misses, three snoops and a full flush walk
  initial begin
    int miss_cycles;
    int budget;
    miss_cycles = 4 * (cpu_types_pkg::RAM_LATENCY + 1) + 2;
    budget = 4 + 30 * (miss_cycles + 2) + 3 * 8
           + 2 * cpu_types_pkg::SETS + 8 * (cpu_types_pkg::RAM_LATENCY + 2) + 50;
    #(budget * 100);
    $display("timeout: the tests did not finish within %0d cycles", budget);
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- vlog.f
cpu_types_pkg.sv
dcache.sv
ram.sv
coherence_control.sv
caches_top.sv
tb_caches.sv
